// ==== hdl/imuldiv_pkg.sv ====
// shared widths, function codes and payload structs of the multiply/divide unit
// every module of the unit imports this package with a wildcard import

package imuldiv_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  // operand width of the core
  localparam int xlen = 32;
  // double-width product and remainder/quotient pair
  localparam int dw = 2 * xlen;

  // step counter covers one step per operand bit
  localparam int cnt_w = 5;
  localparam logic [cnt_w-1:0] cnt_last = '1;

  // --------------------------------------------------
  // function codes
  // --------------------------------------------------

  typedef enum logic [2:0] {
    fn_mul  = 3'd0,   // signed product, full 64 bits
    fn_div  = 3'd1,
    fn_divu = 3'd2,
    fn_rem  = 3'd3,
    fn_remu = 3'd4
  } imuldiv_fn_t;

  // control states of both iterative engines
  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } eng_state_t;

  // --------------------------------------------------
  // payloads
  // --------------------------------------------------

  // request as it arrives from the core
  typedef struct packed {
    imuldiv_fn_t     fn;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } imuldiv_req_t;

  // operation after sign stripping, handed to one engine
  typedef struct packed {
    imuldiv_fn_t     fn;
    logic [xlen-1:0] a_mag;
    logic [xlen-1:0] b_mag;
    logic            neg_quot;   // negate product or quotient
    logic            neg_rem;    // negate remainder
    logic            div_zero;   // divisor was zero
    logic [xlen-1:0] a_raw;      // dividend as given, returned as rem on div by zero
  } imuldiv_op_t;

  // engine output, unsigned result plus the tags retire needs
  typedef struct packed {
    logic [dw-1:0]   prod_or_qr; // product, or {remainder, quotient}
    imuldiv_fn_t     fn;
    logic            neg_quot;
    logic            neg_rem;
    logic            div_zero;
    logic [xlen-1:0] a_raw;
  } imuldiv_raw_t;

  // final response to the core
  typedef struct packed {
    logic [dw-1:0] result;
  } imuldiv_resp_t;

endpackage

// ==== hdl/imuldiv_pipe_reg.sv ====
// one-entry valid/ready pipeline buffer, payload type set by parameter
// used for both the request and the response side of the unit

module imuldiv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,

  // upstream side
  input  logic     in_val,
  output logic     in_rdy,
  input  payload_t in_data,

  // downstream side
  output logic     out_val,
  input  logic     out_rdy,
  output payload_t out_data
);

  logic     full;
  payload_t data_q;
  logic     load;

  // --------------------------------------------------
  // handshake
  // --------------------------------------------------

  // accept when empty, or when the held entry leaves this cycle
  assign in_rdy  = !full || out_rdy;
  assign load    = in_val && in_rdy;
  assign out_val = full;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (out_rdy) begin
      // drained with nothing new behind it
      full <= 1'b0;
    end
  end

  // payload register, only written on a transfer in
  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= in_data;
    end
  end

  assign out_data = data_q;

  // a stalled entry must stay put until it is taken
  a_hold_stable: assert property (@(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> out_val && $stable(out_data));

endmodule

// ==== hdl/imuldiv_issue.sv ====
// issue stage, strips operand signs and dispatches to one of the two engines
// purely combinational, dispatch happens in the cycle the request transfers

module imuldiv_issue import imuldiv_pkg::*; (
  // request buffer side
  input  logic         in_val,
  output logic         in_rdy,
  input  imuldiv_req_t in_req,

  // multiplier engine
  output logic         mul_val,
  input  logic         mul_rdy,

  // divider engine
  output logic         div_val,
  input  logic         div_rdy,

  // operation shared by both engines
  output imuldiv_op_t  op
);

  logic is_mul;
  logic is_signed;
  logic is_rem;
  logic a_neg;
  logic b_neg;

  // --------------------------------------------------
  // decode
  // --------------------------------------------------

  assign is_mul    = (in_req.fn == fn_mul);
  assign is_rem    = (in_req.fn == fn_rem);
  // only the signed functions look at the sign bits
  assign is_signed = (in_req.fn == fn_mul) || (in_req.fn == fn_div) || is_rem;

  assign a_neg = is_signed && in_req.a[xlen-1];
  assign b_neg = is_signed && in_req.b[xlen-1];

  // --------------------------------------------------
  // dispatch
  // --------------------------------------------------

  // wait for both engines idle so only one op is ever in flight
  assign in_rdy  = mul_rdy && div_rdy;
  assign mul_val = in_val && is_mul && div_rdy;
  assign div_val = in_val && !is_mul && mul_rdy;

  // --------------------------------------------------
  // operation fields
  // --------------------------------------------------

  always_comb begin
    op.fn    = in_req.fn;
    // two's complement magnitude, most negative value maps onto itself
    op.a_mag = a_neg ? -in_req.a : in_req.a;
    op.b_mag = b_neg ? -in_req.b : in_req.b;
    // product and quotient flip when exactly one operand is negative
    op.neg_quot = !is_rem && (a_neg ^ b_neg);
    // remainder follows the dividend sign
    op.neg_rem  = is_rem && a_neg;
    op.div_zero = (in_req.b == '0);
    op.a_raw    = in_req.a;
  end

endmodule

// ==== hdl/imuldiv_mul_iter.sv ====
// iterative shift-and-add multiplier that handles one multiplier bit per cycle
// takes unsigned magnitudes and leaves the sign fix-up to retire

module imuldiv_mul_iter import imuldiv_pkg::*; (
  input  logic         clk,
  input  logic         reset,

  // operation in
  input  logic         in_val,
  output logic         in_rdy,
  input  imuldiv_op_t  in_op,

  // unsigned product out
  output logic         out_val,
  input  logic         out_rdy,
  output imuldiv_raw_t out_raw
);

  // control
  eng_state_t       state;
  logic [cnt_w-1:0] cnt;
  logic             start;
  logic             step;

  // datapath
  logic [dw-1:0]    mcand;
  logic [xlen-1:0]  mplier;
  logic [dw-1:0]    acc;
  imuldiv_op_t      op_q;

  // --------------------------------------------------
  // control FSM
  // --------------------------------------------------

  assign in_rdy  = (state == st_idle);
  assign out_val = (state == st_done);
  assign start   = in_val && in_rdy;
  assign step    = (state == st_calc);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_calc;
          end
        end
        st_calc: begin
          // counter wraps back to zero on the last step
          cnt <= cnt + 1'b1;
          if (cnt == cnt_last) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (out_rdy) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (start) begin
      // multiplicand sits in the low half and walks left
      mcand  <= {{xlen{1'b0}}, in_op.a_mag};
      mplier <= in_op.b_mag;
      acc    <= '0;
      op_q   <= in_op;
    end else if (step) begin
      // add when the current multiplier bit is set
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  always_comb begin
    out_raw.prod_or_qr = acc;
    out_raw.fn         = op_q.fn;
    out_raw.neg_quot   = op_q.neg_quot;
    out_raw.neg_rem    = op_q.neg_rem;
    out_raw.div_zero   = op_q.div_zero;
    out_raw.a_raw      = op_q.a_raw;
  end

  // step count rests at zero outside CALC and only advances while calculating
  a_cnt_calc_only: assert property (@(posedge clk) disable iff (reset)
    (state != st_calc) |-> (cnt == '0));

endmodule

// ==== hdl/imuldiv_div_iter.sv ====
// iterative restoring divider, one quotient bit per cycle
// works on magnitudes, leaves {remainder, quotient} in one 64-bit register

module imuldiv_div_iter import imuldiv_pkg::*; (
  input  logic         clk,
  input  logic         reset,

  // operation in
  input  logic         in_val,
  output logic         in_rdy,
  input  imuldiv_op_t  in_op,

  // unsigned remainder and quotient out
  output logic         out_val,
  input  logic         out_rdy,
  output imuldiv_raw_t out_raw
);

  // control
  eng_state_t       state;
  logic [cnt_w-1:0] cnt;
  logic             start;
  logic             step;

  // datapath
  logic [dw-1:0]    rq;         // upper half remainder, lower half dividend/quotient
  logic [xlen-1:0]  divisor_q;
  logic [xlen:0]    rem_sh;     // partial remainder after the shift, one extra bit
  logic [xlen+1:0]  diff;
  logic             q_bit;
  imuldiv_op_t      op_q;

  // --------------------------------------------------
  // control FSM
  // --------------------------------------------------

  assign in_rdy  = (state == st_idle);
  assign out_val = (state == st_done);
  assign start   = in_val && in_rdy;
  assign step    = (state == st_calc);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_calc;
          end
        end
        st_calc: begin
          cnt <= cnt + 1'b1;
          // 32 steps, then hold the result
          if (cnt == cnt_last) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (out_rdy) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  // shift left by one, top dividend bit drops into the remainder
  assign rem_sh = rq[dw-1:xlen-1];
  assign diff   = {1'b0, rem_sh} - {2'b0, divisor_q};
  // subtraction fits when the difference is not negative
  assign q_bit  = !diff[xlen+1];

  always_ff @(posedge clk) begin
    if (start) begin
      rq        <= {{xlen{1'b0}}, in_op.a_mag};
      divisor_q <= in_op.b_mag;
      op_q      <= in_op;
    end else if (step) begin
      if (q_bit) begin
        rq <= {diff[xlen-1:0], rq[xlen-2:0], 1'b1};
      end else begin
        // restore, keep the shifted remainder
        rq <= {rem_sh[xlen-1:0], rq[xlen-2:0], 1'b0};
      end
    end
  end

  always_comb begin
    out_raw.prod_or_qr = rq;
    out_raw.fn         = op_q.fn;
    out_raw.neg_quot   = op_q.neg_quot;
    out_raw.neg_rem    = op_q.neg_rem;
    out_raw.div_zero   = op_q.div_zero;
    out_raw.a_raw      = op_q.a_raw;
  end

  // outside of a load, quotient bits move only during the step phase
  a_quot_calc_only: assert property (@(posedge clk) disable iff (reset)
    (state != st_calc) && !start |=> $stable(rq[xlen-1:0]));

endmodule

// ==== hdl/imuldiv_retire.sv ====
// retire stage, picks the finished engine and applies sign and div-by-zero rules
// combinational, the response buffer behind it does the registering

module imuldiv_retire import imuldiv_pkg::*; (
  // multiplier engine
  input  logic          mul_val,
  output logic          mul_rdy,
  input  imuldiv_raw_t  mul_raw,

  // divider engine
  input  logic          div_val,
  output logic          div_rdy,
  input  imuldiv_raw_t  div_raw,

  // response buffer side
  output logic          out_val,
  input  logic          out_rdy,
  output imuldiv_resp_t out_resp
);

  imuldiv_raw_t    raw;
  logic [dw-1:0]   prod;
  logic [xlen-1:0] quot;
  logic [xlen-1:0] rem;
  logic [xlen-1:0] word;

  // only one engine can be done at a time, so both see the same rdy
  assign out_val = mul_val || div_val;
  assign mul_rdy = out_rdy;
  assign div_rdy = out_rdy;

  // --------------------------------------------------
  // result
  // --------------------------------------------------

  always_comb begin
    raw  = mul_val ? mul_raw : div_raw;
    prod = raw.neg_quot ? -raw.prod_or_qr : raw.prod_or_qr;
    if (raw.div_zero) begin
      // quotient all ones, remainder is the untouched dividend
      quot = '1;
      rem  = raw.a_raw;
    end else begin
      quot = raw.neg_quot ? -raw.prod_or_qr[xlen-1:0] : raw.prod_or_qr[xlen-1:0];
      rem  = raw.neg_rem ? -raw.prod_or_qr[dw-1:xlen] : raw.prod_or_qr[dw-1:xlen];
    end
    word = (raw.fn == fn_rem || raw.fn == fn_remu) ? rem : quot;
    // 32-bit results come back sign-extended
    if (raw.fn == fn_mul) begin
      out_resp.result = prod;
    end else begin
      out_resp.result = {{xlen{word[xlen-1]}}, word};
    end
  end

  // the issue stage keeps a single op in flight across both engines
  always_comb begin
    a_one_engine: assert (mul_val !== 1'b1 || div_val !== 1'b1);
  end

endmodule

// ==== hdl/imuldiv_top.sv ====
// multiply/divide unit top, request buffer -> issue -> engines -> retire -> response buffer
// val/rdy on both ends, responses come back in request order

module imuldiv_top import imuldiv_pkg::*; (
  input  logic          clk,
  input  logic          reset,

  input  logic          req_val,
  output logic          req_rdy,
  input  imuldiv_req_t  req,

  output logic          resp_val,
  input  logic          resp_rdy,
  output imuldiv_resp_t resp
);

  // request buffer to issue
  logic          iss_val;
  logic          iss_rdy;
  imuldiv_req_t  iss_req;

  // issue to engines
  logic          mul_in_val;
  logic          mul_in_rdy;
  logic          div_in_val;
  logic          div_in_rdy;
  imuldiv_op_t   op;

  // engines to retire
  logic          mul_out_val;
  logic          mul_out_rdy;
  imuldiv_raw_t  mul_raw;
  logic          div_out_val;
  logic          div_out_rdy;
  imuldiv_raw_t  div_raw;

  // retire to response buffer
  logic          ret_val;
  logic          ret_rdy;
  imuldiv_resp_t ret_resp;

  imuldiv_pipe_reg #(.payload_t(imuldiv_req_t)) i_req_buf (
    .clk, .reset,
    .in_val (req_val), .in_rdy (req_rdy), .in_data (req),
    .out_val (iss_val), .out_rdy (iss_rdy), .out_data (iss_req)
  );

  imuldiv_issue i_issue (
    .in_val (iss_val), .in_rdy (iss_rdy), .in_req (iss_req),
    .mul_val (mul_in_val), .mul_rdy (mul_in_rdy),
    .div_val (div_in_val), .div_rdy (div_in_rdy),
    .op
  );

  imuldiv_mul_iter i_mul (
    .clk, .reset,
    .in_val (mul_in_val), .in_rdy (mul_in_rdy), .in_op (op),
    .out_val (mul_out_val), .out_rdy (mul_out_rdy), .out_raw (mul_raw)
  );

  imuldiv_div_iter i_div (
    .clk, .reset,
    .in_val (div_in_val), .in_rdy (div_in_rdy), .in_op (op),
    .out_val (div_out_val), .out_rdy (div_out_rdy), .out_raw (div_raw)
  );

  imuldiv_retire i_retire (
    .mul_val (mul_out_val), .mul_rdy (mul_out_rdy), .mul_raw (mul_raw),
    .div_val (div_out_val), .div_rdy (div_out_rdy), .div_raw (div_raw),
    .out_val (ret_val), .out_rdy (ret_rdy), .out_resp (ret_resp)
  );

  imuldiv_pipe_reg #(.payload_t(imuldiv_resp_t)) i_resp_buf (
    .clk, .reset,
    .in_val (ret_val), .in_rdy (ret_rdy), .in_data (ret_resp),
    .out_val (resp_val), .out_rdy (resp_rdy), .out_data (resp)
  );

endmodule

// ==== tests/imuldiv_tb.sv ====
// testbench for the multiply/divide unit with random requests checked against a model
// runs corner pairs, random ops under response back-pressure, then back-to-back ops

module imuldiv_tb import imuldiv_pkg::*;;

  logic          clk = 1'b0;
  logic          reset;
  logic          req_val;
  logic          req_rdy;
  imuldiv_req_t  req;
  logic          resp_val;
  logic          resp_rdy;
  imuldiv_resp_t resp;

  integer      seed    = 32'h942e;
  integer      bp_seed = 32'h942e;
  logic [63:0] exp_q[$];
  logic [63:0] exp_front;
  logic        bp_on = 1'b0;
  logic        saw_full_stall = 1'b0;
  logic [31:0] corners [5] = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff};
  imuldiv_fn_t fns [5] = '{fn_mul, fn_div, fn_divu, fn_rem, fn_remu};

  imuldiv_top i_imuldiv_top (
    .clk, .reset,
    .req_val, .req_rdy, .req,
    .resp_val, .resp_rdy, .resp
  );

  always #4 clk = ~clk;

  // --------------------------------------------------
  // checking
  // --------------------------------------------------

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s at time %0t", why, $time);
    $display("** FAIL **");
    $fatal(1, "run aborted");
  endtask

  // reference model in native 64-bit arithmetic with truncating division
  function automatic logic [63:0] model_result(input imuldiv_fn_t fn,
                                               input logic [31:0] a, input logic [31:0] b);
    longint      sa;
    longint      sb;
    logic [63:0] full;
    logic [31:0] word;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (fn == fn_mul) begin
      return sa * sb;
    end
    if (b == '0) begin
      // quotient all ones and remainder equal to the dividend
      word = (fn == fn_div || fn == fn_divu) ? 32'hffffffff : a;
    end else begin
      case (fn)
        fn_div:  full = sa / sb;
        fn_rem:  full = sa % sb;
        fn_divu: full = {32'b0, a} / {32'b0, b};
        default: full = {32'b0, a} % {32'b0, b};
      endcase
      word = full[31:0];
    end
    return {{32{word[31]}}, word};
  endfunction

  // watch both handshakes once per cycle at the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      if (req_val && !req_rdy && resp_val && !resp_rdy) begin
        saw_full_stall = 1'b1;
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(model_result(req.fn, req.a, req.b));
      end
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          abort_run("response arrived with no request outstanding");
        end else begin
          exp_front = exp_q.pop_front();
          check_value("response result", resp.result, exp_front);
        end
      end
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  // response back-pressure in low and high stretches of random length
  initial begin
    int          hold;
    logic [31:0] r;
    hold = 0;
    resp_rdy = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (!bp_on) begin
        resp_rdy = 1'b1;
      end else if (hold == 0) begin
        r = $random(bp_seed);
        resp_rdy = r[0];
        // long low stretches let the whole pipeline fill up
        hold = r[0] ? int'(r[3:1]) : int'(r[6:1]);
      end else begin
        hold--;
      end
    end
  end

  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    int          idx;
    r = $random(seed);
    idx = int'(r[10:3]) % 5;
    // one in eight operands is a corner value
    return (r[2:0] == 3'd0) ? corners[idx] : $random(seed);
  endfunction

  function automatic imuldiv_fn_t pick_fn();
    logic [31:0] r;
    int          idx;
    r = $random(seed);
    idx = int'(r[7:0]) % 5;
    return fns[idx];
  endfunction

  // hold the request until it transfers and drop it just after that rising edge
  task automatic send_req(input imuldiv_fn_t fn, input logic [31:0] a, input logic [31:0] b);
    int waited;
    waited = 0;
    req_val = 1'b1;
    req.fn = fn;
    req.a = a;
    req.b = b;
    @(negedge clk);
    while (!req_rdy) begin
      waited++;
      if (waited > 2000) begin
        abort_run("timeout, req_rdy stayed low");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_val = 1'b0;
  endtask

  task automatic drain(input int limit);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > limit) begin
        abort_run("timeout, responses still outstanding");
      end
      @(posedge clk);
    end
  endtask

  initial begin
    int          f;
    int          i;
    int          j;
    imuldiv_fn_t fn_r;
    logic [31:0] a_r;
    logic [31:0] b_r;
    logic [31:0] r;
    reset = 1'b1;
    req_val = 1'b0;
    req = '0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_value("req_rdy after reset", {63'b0, req_rdy}, 64'd1);
    check_value("resp_val after reset", {63'b0, resp_val}, 64'd0);
    @(posedge clk);
    #1;
    // every function on every corner pair including div by zero and min / -1
    for (f = 0; f < 5; f++) begin
      for (i = 0; i < 5; i++) begin
        for (j = 0; j < 5; j++) begin
          send_req(fns[f], corners[i], corners[j]);
        end
      end
    end
    drain(2000);
    // random ops with random response stalls and idle gaps
    bp_on = 1'b1;
    #1;
    repeat (150) begin
      fn_r = pick_fn();
      a_r = pick_operand();
      b_r = pick_operand();
      send_req(fn_r, a_r, b_r);
      r = $random(seed);
      if (r[3:0] == 4'd0) begin
        @(posedge clk);
        #1;
      end
    end
    drain(5000);
    // back-to-back requests with the response side always ready
    bp_on = 1'b0;
    #1;
    repeat (60) begin
      fn_r = pick_fn();
      a_r = pick_operand();
      b_r = pick_operand();
      send_req(fn_r, a_r, b_r);
    end
    drain(2000);
    // idle for longer than one operation so a repeated response still shows up
    repeat (80) @(posedge clk);
    check_value("req_rdy low with full pipeline", {63'b0, saw_full_stall}, 64'd1);
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/imuldiv_pkg.sv
hdl/imuldiv_pipe_reg.sv
hdl/imuldiv_issue.sv
hdl/imuldiv_mul_iter.sv
hdl/imuldiv_div_iter.sv
hdl/imuldiv_retire.sv
hdl/imuldiv_top.sv
tests/imuldiv_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the multiply/divide unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module imuldiv_tb -o imuldiv_sim
./obj_dir/imuldiv_sim | tee sim.log

if grep -qF '** PASS **' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
